// File: include/zx_audio_config.svh
`ifndef ZX_AUDIO_CONFIG_SVH
`define ZX_AUDIO_CONFIG_SVH

////////////////////////////////////////////////////////////
// I/O port map
////////////////////////////////////////////////////////////

`define ZX_PORT_ULA      16'h00FE  // Speaker, MIC out, EAR in
`define ZX_PORT_REGADDR  16'hFC3B  // ZX-Uno register index
`define ZX_PORT_REGDATA  16'hFD3B  // ZX-Uno register data

// Read-only value behind REG_ID
`define ZX_CORE_ID       8'h5A

////////////////////////////////////////////////////////////
// Audio
////////////////////////////////////////////////////////////

// DAC accumulator width, one period is 2**width cycles
`define ZX_DAC_WIDTH     8

`endif

// File: src/zx_io_pkg.sv
package zx_io_pkg;

  ////////////////////////////////////////////////////////////
  // ZX-Uno register indices behind port 0xFD3B
  ////////////////////////////////////////////////////////////

  typedef enum logic [7:0] {
    REG_ID      = 8'h00,  // Core ID, read only
    REG_MIXMASK = 8'h01,  // Bit 3 AY, 2 EAR, 1 MIC, 0 SPK
    REG_AYLEVEL = 8'h02,  // AY output level
    REG_VOLUME  = 8'h03   // Bits 1..0 right shift of the mix
  } zx_reg_e;

  ////////////////////////////////////////////////////////////
  // APB slave phases
  ////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    APB_IDLE   = 2'd0,  // psel low
    APB_SETUP  = 2'd1,  // psel high, penable low
    APB_ACCESS = 2'd2   // Transfer completes here
  } apb_state_e;

endpackage

// File: src/zx_audio_pkg.sv
package zx_audio_pkg;

  // Sound sources, value is the bit position in the mix mask
  typedef enum logic [1:0] {
    SRC_SPK = 2'd0,
    SRC_MIC = 2'd1,
    SRC_EAR = 2'd2,
    SRC_AY  = 2'd3
  } audio_src_e;

  ////////////////////////////////////////////////////////////
  // Fixed levels for the 1-bit sources
  ////////////////////////////////////////////////////////////

  localparam logic [7:0] LVL_SPK = 8'd96;  // Beeper dominates
  localparam logic [7:0] LVL_MIC = 8'd16;  // Tape out, quiet
  localparam logic [7:0] LVL_EAR = 8'd32;  // Tape in monitor

endpackage

// File: src/apb_io_decoder.sv
`include "zx_audio_config.svh"

module apb_io_decoder import zx_io_pkg::*; (
  input  logic        clk,
  input  logic        arst_n,
  input  logic [15:0] paddr,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [7:0]  pwdata,
  input  logic        ear,
  input  logic [7:0]  reg_rd_data,  // From register file
  output logic [7:0]  prdata,
  output logic        pready,
  output logic        pslverr,
  output logic        spk,
  output logic        mic,
  output zx_reg_e     reg_index,
  output logic        reg_wr,
  output logic [7:0]  reg_wdata
);

  apb_state_e state;
  apb_state_e state_nxt;
  logic       port_ula;
  logic       port_addr;
  logic       port_data;
  logic       access;    // Single access cycle of a transfer
  logic       err;
  logic       wr_ok;     // Error-free write in this cycle

  ////////////////////////////////////////////////////////////
  // Bus phase tracking
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_nxt = state;
    case (state)
      APB_IDLE:   if (psel && !penable) state_nxt = APB_SETUP;
      APB_SETUP: begin
        if (psel && penable) state_nxt = APB_ACCESS;
        else if (!psel)      state_nxt = APB_IDLE;
      end
      APB_ACCESS: begin
        if (psel && !penable) state_nxt = APB_SETUP;  // Back to back
        else if (!psel)       state_nxt = APB_IDLE;
      end
      default:    state_nxt = APB_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) state <= APB_IDLE;
    else         state <= state_nxt;
  end

  // Only the first enable cycle after setup counts, no wait states
  assign access = psel && penable && (state == APB_SETUP);

  ////////////////////////////////////////////////////////////
  // Port decode and error
  ////////////////////////////////////////////////////////////

  assign port_ula  = (paddr == `ZX_PORT_ULA);
  assign port_addr = (paddr == `ZX_PORT_REGADDR);
  assign port_data = (paddr == `ZX_PORT_REGDATA);

  // Unknown port, or write to the ID register
  assign err = !(port_ula || port_addr || port_data) ||
               (port_data && pwrite && (reg_index == REG_ID));

  assign pready  = access;
  assign pslverr = access && err;
  assign wr_ok   = access && pwrite && !err;

  // Register file strobe
  assign reg_wr    = wr_ok && port_data;
  assign reg_wdata = pwdata;

  // ULA latch and index register
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      spk       <= 1'b0;
      mic       <= 1'b0;
      reg_index <= REG_ID;
    end else if (wr_ok) begin
      if (port_ula) begin
        spk <= pwdata[4];  // Bit 4 speaker
        mic <= pwdata[3];  // Bit 3 MIC
      end
      if (port_addr) reg_index <= zx_reg_e'(pwdata);  // Any index accepted
    end
  end

  // Read mux, zero outside the access cycle
  always_comb begin
    prdata = 8'h00;
    if (access && !pwrite) begin
      if (port_ula)       prdata = {1'b1, ear, 6'h3F};  // 0xBF, EAR on bit 6
      else if (port_addr) prdata = reg_index;
      else if (port_data) prdata = reg_rd_data;
    end
  end

endmodule

// File: src/zxuno_regfile.sv
`include "zx_audio_config.svh"

module zxuno_regfile import zx_io_pkg::*; (
  input  logic       clk,
  input  logic       arst_n,
  input  zx_reg_e    reg_index,
  input  logic       reg_wr,     // One-cycle strobe from decoder
  input  logic [7:0] reg_wdata,
  output logic [7:0] reg_rd_data,
  output logic [3:0] mix_mask,
  output logic [7:0] ay_level,
  output logic [1:0] vol_shift
);

  ////////////////////////////////////////////////////////////
  // Writable registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      mix_mask  <= 4'hF;  // All sources on
      ay_level  <= 8'h00;
      vol_shift <= 2'd0;  // Full volume
    end else if (reg_wr) begin
      case (reg_index)
        REG_MIXMASK: mix_mask  <= reg_wdata[3:0];
        REG_AYLEVEL: ay_level  <= reg_wdata;
        REG_VOLUME:  vol_shift <= reg_wdata[1:0];
        default: ;  // ID and unmapped indices ignore writes
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Read side
  ////////////////////////////////////////////////////////////

  // Combinational from the index, decoder samples it in the access cycle
  always_comb begin
    case (reg_index)
      REG_ID:      reg_rd_data = `ZX_CORE_ID;
      REG_MIXMASK: reg_rd_data = {4'h0, mix_mask};   // Upper bits zero
      REG_AYLEVEL: reg_rd_data = ay_level;
      REG_VOLUME:  reg_rd_data = {6'h00, vol_shift};
      default:     reg_rd_data = 8'hFF;              // Unmapped
    endcase
  end

endmodule

// File: src/audio_level_stage.sv
module audio_level_stage import zx_audio_pkg::*; (
  input  logic       clk,
  input  logic       arst_n,
  input  logic       spk,
  input  logic       mic,
  input  logic       ear,
  input  logic [3:0] mix_mask,
  input  logic [7:0] ay_level,
  output logic [7:0] lvl_spk,
  output logic [7:0] lvl_mic,
  output logic [7:0] lvl_ear,
  output logic [7:0] lvl_ay
);

  logic [7:0] spk_d;  // Next levels
  logic [7:0] mic_d;
  logic [7:0] ear_d;
  logic [7:0] ay_d;

  ////////////////////////////////////////////////////////////
  // Source to level, masked
  ////////////////////////////////////////////////////////////

  always_comb begin
    spk_d = (spk && mix_mask[SRC_SPK]) ? LVL_SPK : 8'd0;
    mic_d = (mic && mix_mask[SRC_MIC]) ? LVL_MIC : 8'd0;
    ear_d = (ear && mix_mask[SRC_EAR]) ? LVL_EAR : 8'd0;
    // AY already a level, only the mask applies
    ay_d  = mix_mask[SRC_AY] ? ay_level : 8'd0;
  end

  // Pipeline register, stage 1
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      lvl_spk <= 8'd0;
      lvl_mic <= 8'd0;
      lvl_ear <= 8'd0;
      lvl_ay  <= 8'd0;
    end else begin
      lvl_spk <= spk_d;
      lvl_mic <= mic_d;
      lvl_ear <= ear_d;
      lvl_ay  <= ay_d;
    end
  end

endmodule

// File: src/audio_sum_stage.sv
`include "zx_audio_config.svh"

module audio_sum_stage import zx_audio_pkg::*; (
  input  logic       clk,
  input  logic       arst_n,
  input  logic [7:0] lvl_spk,
  input  logic [7:0] lvl_mic,
  input  logic [7:0] lvl_ear,
  input  logic [7:0] lvl_ay,
  input  logic [1:0] vol_shift,
  output logic [7:0] sample
);

  // Two guard bits cover four 8-bit terms
  localparam int SW = `ZX_DAC_WIDTH + 2;

  logic [7:0]    lvl [4];  // Indexed by source
  logic [SW-1:0] sum;
  logic [7:0]    clipped;

  assign lvl[SRC_SPK] = lvl_spk;
  assign lvl[SRC_MIC] = lvl_mic;
  assign lvl[SRC_EAR] = lvl_ear;
  assign lvl[SRC_AY]  = lvl_ay;

  ////////////////////////////////////////////////////////////
  // Mix, clip, volume
  ////////////////////////////////////////////////////////////

  always_comb begin
    sum = '0;
    for (int i = 0; i < 4; i++) begin
      sum = sum + SW'(lvl[i]);
    end
    clipped = (sum > SW'(255)) ? 8'hFF : sum[7:0];  // Saturate at 255
  end

  // Pipeline register, stage 2
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) sample <= 8'd0;
    else         sample <= clipped >> vol_shift;  // Volume as right shift
  end

endmodule

// File: src/sigma_delta_dac.sv
`include "zx_audio_config.svh"

module sigma_delta_dac (
  input  logic       clk,
  input  logic       arst_n,
  input  logic [7:0] sample,
  output logic       audio_out  // Pulse density output pin
);

  localparam int W = `ZX_DAC_WIDTH;

  logic [W-1:0] acc;
  logic [W:0]   acc_sum;  // Top bit is the carry

  ////////////////////////////////////////////////////////////
  // First-order modulator
  ////////////////////////////////////////////////////////////

  assign acc_sum = (W+1)'(acc) + (W+1)'(sample);

  // Carry density equals sample / 2**W
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      acc       <= '0;
      audio_out <= 1'b0;
    end else begin
      acc       <= acc_sum[W-1:0];  // Wraps, keeps residue
      audio_out <= acc_sum[W];
    end
  end

endmodule

// File: src/zx_audio_top.sv
module zx_audio_top import zx_io_pkg::*; (
  input  logic        clk,
  input  logic        arst_n,
  // APB slave
  input  logic [15:0] paddr,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [7:0]  pwdata,
  output logic [7:0]  prdata,
  output logic        pready,
  output logic        pslverr,
  // Pins
  input  logic        ear,       // Tape input
  output logic        audio_out  // Sigma-delta output
);

  // ULA latch bits
  logic       spk;
  logic       mic;
  // Register file access
  zx_reg_e    reg_index;
  logic       reg_wr;
  logic [7:0] reg_wdata;
  logic [7:0] reg_rd_data;
  // Mixer controls
  logic [3:0] mix_mask;
  logic [7:0] ay_level;
  logic [1:0] vol_shift;
  // Pipeline
  logic [7:0] lvl_spk;
  logic [7:0] lvl_mic;
  logic [7:0] lvl_ear;
  logic [7:0] lvl_ay;
  logic [7:0] sample;

  ////////////////////////////////////////////////////////////
  // Bus side
  ////////////////////////////////////////////////////////////

  apb_io_decoder u_decoder (
    .clk, .arst_n,
    .paddr, .psel, .penable, .pwrite, .pwdata,
    .ear,
    .reg_rd_data,
    .prdata, .pready, .pslverr,
    .spk, .mic,
    .reg_index, .reg_wr, .reg_wdata
  );

  zxuno_regfile u_regfile (
    .clk, .arst_n,
    .reg_index, .reg_wr, .reg_wdata,
    .reg_rd_data,
    .mix_mask, .ay_level, .vol_shift
  );

  ////////////////////////////////////////////////////////////
  // Audio pipeline, three stages
  ////////////////////////////////////////////////////////////

  audio_level_stage u_level (
    .clk, .arst_n,
    .spk, .mic, .ear,
    .mix_mask, .ay_level,
    .lvl_spk, .lvl_mic, .lvl_ear, .lvl_ay
  );

  audio_sum_stage u_sum (
    .clk, .arst_n,
    .lvl_spk, .lvl_mic, .lvl_ear, .lvl_ay,
    .vol_shift,
    .sample
  );

  sigma_delta_dac u_dac (
    .clk, .arst_n,
    .sample,
    .audio_out
  );

endmodule

// File: verif/zx_audio_sva.sv
module zx_audio_sva import zx_io_pkg::*; (
  input logic       clk,
  input logic       arst_n,
  input logic       psel,
  input logic       penable,
  input logic       pready,
  input logic       pslverr,
  input apb_state_e state,
  input logic       audio_out
);

  ////////////////////////////////////////////////////////////
  // APB slave
  ////////////////////////////////////////////////////////////

  a_ready_access: assert property (@(posedge clk) disable iff (!arst_n)
    pready |-> psel && penable)
    else $error("pready outside an access phase");

  // No wait states, the FSM leaves setup once ready is given
  a_ready_once: assert property (@(posedge clk) disable iff (!arst_n)
    pready |=> state == APB_ACCESS)
    else $error("FSM not in access after pready");

  a_err_ready: assert property (@(posedge clk) disable iff (!arst_n)
    pslverr |-> pready)
    else $error("pslverr without pready");

  // DAC pin quiet in reset
  a_dac_reset: assert property (@(posedge clk) !arst_n |-> !audio_out)
    else $error("audio_out high during reset");

endmodule

bind apb_io_decoder zx_audio_sva u_apb_sva (
  .clk, .arst_n, .psel, .penable, .pready, .pslverr, .state,
  .audio_out (1'b0)
);

bind sigma_delta_dac zx_audio_sva u_dac_sva (
  .clk, .arst_n,
  .psel (1'b0), .penable (1'b0), .pready (1'b0), .pslverr (1'b0),
  .state (zx_io_pkg::APB_IDLE),
  .audio_out
);

// File: verif/zx_audio_tb.sv
`include "zx_audio_config.svh"

module zx_audio_tb import zx_io_pkg::*; ();

  localparam int TIMEOUT = 50;  // Cycles allowed per APB wait
  localparam int N_DAC   = 8;

  // Columns ULA byte, mix mask, AY level, volume, ear, expected ones count
  localparam logic [7:0] DAC_TAB [N_DAC][6] = '{
    '{8'h18, 8'h0F, 8'd0,   8'd0, 8'd0, 8'd112},  // SPK 96 + MIC 16
    '{8'h10, 8'h0F, 8'd100, 8'd0, 8'd1, 8'd228},  // SPK + EAR 32 + AY
    '{8'h18, 8'h0F, 8'd200, 8'd0, 8'd1, 8'd255},  // 344 clips
    '{8'h18, 8'h0F, 8'd200, 8'd2, 8'd1, 8'd63},   // Clip, then /4
    '{8'h18, 8'h00, 8'd200, 8'd0, 8'd1, 8'd0},    // Fully masked
    '{8'h18, 8'h05, 8'd50,  8'd1, 8'd1, 8'd64},   // SPK + EAR only, /2
    '{8'h00, 8'h08, 8'd77,  8'd0, 8'd1, 8'd77},   // AY alone
    '{8'h08, 8'h0F, 8'd10,  8'd3, 8'd0, 8'd3}     // MIC + AY, /8
  };

  logic        clk;
  logic        arst_n;
  logic [15:0] paddr;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [7:0]  pwdata;
  logic [7:0]  prdata;
  logic        pready;
  logic        pslverr;
  logic        ear;
  logic        audio_out;
  int          tests;
  int          checks;
  int          errors;
  logic [31:0] lcg_state;

  zx_audio_top DUT (.*);

  always #2 clk = ~clk;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic check(input string name, input int got, input int exp);
    checks++;
    if (got != exp) begin
      errors++;
      $display("Fail at %0t: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
    end
  endtask

  task automatic finish_run();
    $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) $display("Everything OK");
    else $display("Something failed");
    $finish;
  endtask

  task automatic test_done(input string name, input int errs_before);
    tests++;
    $display("Test %-12s %s", name, (errors == errs_before) ? "ok" : "mismatch");
  endtask

  ////////////////////////////////////////////////////////////
  // APB master
  ////////////////////////////////////////////////////////////

  task automatic apb_xfer(input logic [15:0] addr, input logic wr, input logic [7:0] wdata,
                          output logic [7:0] rdata, output logic err);
    int n;
    @(posedge clk);
    paddr   <= addr;  // Setup phase
    pwrite  <= wr;
    pwdata  <= wdata;
    psel    <= 1'b1;
    penable <= 1'b0;
    @(posedge clk);
    penable <= 1'b1;
    n = 0;
    @(negedge clk);
    while (!pready && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (!pready) begin
      $display("Timeout: port 0x%04h never raised pready in %0d cycles", addr, TIMEOUT);
      errors++;
      rdata = 8'hxx;
      err   = 1'bx;
    end else begin
      rdata = prdata;   // Mid-cycle, stable
      err   = pslverr;
    end
    @(posedge clk);     // Access ends here
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic reg_write(input logic [7:0] idx, input logic [7:0] data, output logic err);
    logic [7:0] rd;
    apb_xfer(`ZX_PORT_REGADDR, 1'b1, idx, rd, err);
    apb_xfer(`ZX_PORT_REGDATA, 1'b1, data, rd, err);
  endtask

  task automatic reg_read(input logic [7:0] idx, output logic [7:0] data, output logic err);
    apb_xfer(`ZX_PORT_REGADDR, 1'b1, idx, data, err);
    apb_xfer(`ZX_PORT_REGDATA, 1'b0, 8'h00, data, err);
  endtask

  initial begin
    logic [7:0] rd;
    logic [7:0] ay;
    logic       err;
    int         cnt;
    int         e0;
    clk = 1'b0;
    arst_n = 1'b1;
    paddr = 16'h0000;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    pwdata = 8'h00;
    ear = 1'b0;
    tests = 0;
    checks = 0;
    errors = 0;
    lcg_state = 32'd50;
    @(posedge clk);
    arst_n <= 1'b0;
    repeat (8) @(posedge clk);
    arst_n <= 1'b1;

    // Reset values
    e0 = errors;
    reg_read(REG_ID, rd, err);
    check("REG_ID", int'(rd), int'(`ZX_CORE_ID));
    check("pslverr", int'(err), 0);
    reg_read(REG_MIXMASK, rd, err);
    check("REG_MIXMASK", int'(rd), 'h0F);
    reg_read(REG_AYLEVEL, rd, err);
    check("REG_AYLEVEL", int'(rd), 0);
    reg_read(REG_VOLUME, rd, err);
    check("REG_VOLUME", int'(rd), 0);
    test_done("reset", e0);

    // Write and read back, unused bits read zero
    e0 = errors;
    for (int i = 0; i < 4; i++) begin
      lcg_state = lcg_next(lcg_state);
      ay = lcg_state[23:16];
      reg_write(REG_AYLEVEL, ay, err);
      reg_read(REG_AYLEVEL, rd, err);
      check("REG_AYLEVEL", int'(rd), int'(ay));
    end
    reg_write(REG_MIXMASK, 8'hA5, err);
    reg_read(REG_MIXMASK, rd, err);
    check("REG_MIXMASK", int'(rd), 'h05);
    reg_write(REG_VOLUME, 8'hFE, err);
    reg_read(REG_VOLUME, rd, err);
    check("REG_VOLUME", int'(rd), 'h02);
    apb_xfer(`ZX_PORT_REGADDR, 1'b1, 8'h7C, rd, err);
    apb_xfer(`ZX_PORT_REGADDR, 1'b0, 8'h00, rd, err);
    check("reg_index", int'(rd), 'h7C);
    test_done("readback", e0);

    // Bus errors
    e0 = errors;
    apb_xfer(16'h1234, 1'b0, 8'h00, rd, err);
    check("pslverr", int'(err), 1);
    apb_xfer(16'h1234, 1'b1, 8'h55, rd, err);
    check("pslverr", int'(err), 1);
    reg_write(REG_ID, 8'h00, err);  // Read only
    check("pslverr", int'(err), 1);
    reg_read(REG_ID, rd, err);
    check("REG_ID", int'(rd), int'(`ZX_CORE_ID));
    check("pslverr", int'(err), 0);
    reg_read(8'h40, rd, err);       // Unmapped index
    check("unmapped", int'(rd), 'hFF);
    check("pslverr", int'(err), 0);
    test_done("bus errors", e0);

    // ULA read, EAR on bit 6
    e0 = errors;
    @(posedge clk);
    ear <= 1'b0;
    apb_xfer(`ZX_PORT_ULA, 1'b0, 8'h00, rd, err);
    check("ula", int'(rd), 'hBF);
    ear <= 1'b1;
    apb_xfer(`ZX_PORT_ULA, 1'b0, 8'h00, rd, err);
    check("ula", int'(rd), 'hFF);
    test_done("ula", e0);

    // DAC density over one accumulator period
    for (int t = 0; t < N_DAC; t++) begin
      e0 = errors;
      apb_xfer(`ZX_PORT_ULA, 1'b1, DAC_TAB[t][0], rd, err);
      reg_write(REG_MIXMASK, DAC_TAB[t][1], err);
      reg_write(REG_AYLEVEL, DAC_TAB[t][2], err);
      reg_write(REG_VOLUME, DAC_TAB[t][3], err);
      @(posedge clk);
      ear <= DAC_TAB[t][4][0];
      repeat (8) @(posedge clk);  // Pipeline settles
      cnt = 0;
      repeat (1 << `ZX_DAC_WIDTH) begin
        @(negedge clk);
        if (audio_out) cnt++;
      end
      check("audio_out count", cnt, int'(DAC_TAB[t][5]));
      test_done($sformatf("dac %0d", t), e0);
    end

    finish_run();
  end

endmodule

// File: flist.f
+incdir+include
src/zx_io_pkg.sv
src/zx_audio_pkg.sv
src/apb_io_decoder.sv
src/zxuno_regfile.sv
src/audio_level_stage.sv
src/audio_sum_stage.sv
src/sigma_delta_dac.sv
src/zx_audio_top.sv
verif/zx_audio_sva.sv
verif/zx_audio_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module zx_audio_tb \
  --Mdir obj_dir -o zx_audio_sim > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/zx_audio_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Something failed" sim.log; then
  exit 1
fi
exit 0
